//--- hw/wasm_params.svh
`ifndef WASM_PARAMS_SVH
`define WASM_PARAMS_SVH

// memory sizes
`define WASM_IMEM_DEPTH   256
`define WASM_IMEM_AW      8
`define WASM_LMEM_DEPTH   512
`define WASM_LMEM_AW      9

// stack pointer has one spare bit so it can count up to full
`define WASM_STACK_DEPTH  16
`define WASM_SP_W         5

`define WASM_WORD_W       32
`define WASM_INSTR_W      64

// opcode byte values
`define WASM_OP_CONST     8'h41
`define WASM_OP_ADD       8'h6A
`define WASM_OP_SUB       8'h6B
`define WASM_OP_AND       8'h71
`define WASM_OP_OR        8'h72
`define WASM_OP_XOR       8'h73
`define WASM_OP_DROP      8'h1A
`define WASM_OP_LOAD      8'h28
`define WASM_OP_STORE     8'h36
`define WASM_OP_END       8'h0B

`endif

//--- hw/wasm_pkg.sv
`include "wasm_params.svh"

package wasm_pkg;

    typedef logic [`WASM_WORD_W-1:0]  word_t;
    // opcode in 63..56, immediate in 31..0
    typedef logic [`WASM_INSTR_W-1:0] instr_word_t;
    typedef logic [`WASM_IMEM_AW-1:0] imem_addr_t;
    typedef logic [`WASM_LMEM_AW-1:0] lmem_addr_t;
    // equals the number of entries
    typedef logic [`WASM_SP_W-1:0]    sp_t;

    typedef enum logic [1:0] {
        ST_LOAD = 2'b00,
        ST_RUN  = 2'b01,
        ST_DONE = 2'b11
    } run_state_t;

    typedef enum logic [2:0] {
        KIND_ALU,
        KIND_CONST,
        KIND_DROP,
        KIND_LOAD,
        KIND_STORE,
        KIND_NOP
    } exec_kind_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_t;

    typedef struct packed {
        exec_kind_t kind;
        alu_op_t    alu;
        word_t      imm;
    } dec_op_t;

    // pops first, then the optional push
    typedef struct packed {
        logic       commit;
        logic [1:0] pop_num;
        logic       push;
        word_t      push_data;
    } stack_req_t;

    typedef struct packed {
        word_t top;
        word_t next;
        sp_t   count;
    } pop_window_t;

    typedef struct packed {
        logic instr;
        logic overflow;
        logic underflow;
    } err_t;

endpackage

//--- hw/wasm_fetch_decode.sv
`timescale 1ns/1ps
`include "wasm_params.svh"

module wasm_fetch_decode (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_wr_vld,
    input  wasm_pkg::imem_addr_t  i_wr_addr,
    input  wasm_pkg::instr_word_t i_wr_data,
    input  logic                  i_wr_finish,
    input  logic                  i_stall,
    input  logic [1:0]            i_stack_err,
    output logic                  o_wr_rdy,
    output wasm_pkg::run_state_t  o_state,
    output wasm_pkg::dec_op_t     o_op,
    output logic                  o_op_vld,
    output logic                  o_instr_err
);

    wasm_pkg::instr_word_t imem [`WASM_IMEM_DEPTH];
    wasm_pkg::instr_word_t fetch_word;
    logic                  fetch_vld;
    wasm_pkg::imem_addr_t  pc;
    logic                  op_vld_q;
    logic                  op_end_q;
    logic [7:0]            opcode;
    wasm_pkg::dec_op_t     dec_op;
    logic                  dec_end;
    logic                  dec_bad;
    logic                  end_hit;
    logic                  stop;
    logic                  advance;

    assign end_hit = op_vld_q & op_end_q;
    assign stop    = end_hit | o_instr_err | (|i_stack_err);
    // both pipeline stages move together
    assign advance = (o_state == wasm_pkg::ST_RUN) & ~i_stall & ~stop;

    // no op leaves once an error is flagged
    assign o_op_vld = op_vld_q & (o_state == wasm_pkg::ST_RUN)
                      & ~o_instr_err & ~(|i_stack_err);

    always_ff @(posedge i_clk) begin
        if (i_wr_vld && o_wr_rdy) begin
            imem[i_wr_addr] <= i_wr_data;
        end
    end

    // synchronous read, held while stalled
    always_ff @(posedge i_clk) begin
        if (advance) begin
            fetch_word <= imem[pc];
        end
    end

    assign opcode = fetch_word[`WASM_INSTR_W-1 -: 8];

    always_comb begin
        dec_op.kind = wasm_pkg::KIND_NOP;
        dec_op.alu  = wasm_pkg::ALU_ADD;
        dec_op.imm  = fetch_word[`WASM_WORD_W-1:0];
        dec_end     = 1'b0;
        dec_bad     = 1'b0;
        case (opcode)
            `WASM_OP_CONST: dec_op.kind = wasm_pkg::KIND_CONST;
            `WASM_OP_ADD: begin
                dec_op.kind = wasm_pkg::KIND_ALU;
                dec_op.alu  = wasm_pkg::ALU_ADD;
            end
            `WASM_OP_SUB: begin
                dec_op.kind = wasm_pkg::KIND_ALU;
                dec_op.alu  = wasm_pkg::ALU_SUB;
            end
            `WASM_OP_AND: begin
                dec_op.kind = wasm_pkg::KIND_ALU;
                dec_op.alu  = wasm_pkg::ALU_AND;
            end
            `WASM_OP_OR: begin
                dec_op.kind = wasm_pkg::KIND_ALU;
                dec_op.alu  = wasm_pkg::ALU_OR;
            end
            `WASM_OP_XOR: begin
                dec_op.kind = wasm_pkg::KIND_ALU;
                dec_op.alu  = wasm_pkg::ALU_XOR;
            end
            `WASM_OP_DROP:  dec_op.kind = wasm_pkg::KIND_DROP;
            `WASM_OP_LOAD:  dec_op.kind = wasm_pkg::KIND_LOAD;
            `WASM_OP_STORE: dec_op.kind = wasm_pkg::KIND_STORE;
            `WASM_OP_END:   dec_end = 1'b1;
            default:        dec_bad = 1'b1;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (advance) begin
            o_op <= dec_op;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pc          <= '0;
            fetch_vld   <= 1'b0;
            op_vld_q    <= 1'b0;
            op_end_q    <= 1'b0;
            o_instr_err <= 1'b0;
        end else if (advance) begin
            pc        <= pc + 1'b1;
            fetch_vld <= 1'b1;
            op_vld_q  <= fetch_vld;
            op_end_q  <= fetch_vld & dec_end;
            if (fetch_vld && dec_bad) begin
                o_instr_err <= 1'b1;
            end
        end
    end

    // run phase
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_state  <= wasm_pkg::ST_LOAD;
            o_wr_rdy <= 1'b1;
        end else begin
            case (o_state)
                wasm_pkg::ST_LOAD: begin
                    if (i_wr_finish) begin
                        o_state  <= wasm_pkg::ST_RUN;
                        o_wr_rdy <= 1'b0;
                    end
                end
                wasm_pkg::ST_RUN: begin
                    if (stop) begin
                        o_state <= wasm_pkg::ST_DONE;
                    end
                end
                default: o_state <= o_state;
            endcase
        end
    end

endmodule

//--- hw/wasm_operand_stack.sv
`timescale 1ns/1ps
`include "wasm_params.svh"

module wasm_operand_stack (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  wasm_pkg::stack_req_t  i_req,
    output wasm_pkg::pop_window_t o_window,
    output logic                  o_overflow,
    output logic                  o_underflow
);

    localparam int IDX_W = `WASM_SP_W - 1;

    wasm_pkg::word_t  stack_mem [`WASM_STACK_DEPTH];
    wasm_pkg::sp_t    sp;
    wasm_pkg::sp_t    sp_m1;
    wasm_pkg::sp_t    sp_m2;
    wasm_pkg::sp_t    sp_popped;
    logic             pop_bad;
    logic             push_bad;
    logic             wr_en;

    assign sp_m1 = sp - wasm_pkg::sp_t'(1);
    assign sp_m2 = sp - wasm_pkg::sp_t'(2);

    // top and second entry, straight from storage
    always_comb begin
        o_window.top   = stack_mem[sp_m1[IDX_W-1:0]];
        o_window.next  = stack_mem[sp_m2[IDX_W-1:0]];
        o_window.count = sp;
    end

    assign pop_bad   = wasm_pkg::sp_t'(i_req.pop_num) > sp;
    assign sp_popped = sp - wasm_pkg::sp_t'(i_req.pop_num);
    // push after the pops would pass the depth
    assign push_bad  = i_req.push
                       & (sp_popped == wasm_pkg::sp_t'(`WASM_STACK_DEPTH));
    assign wr_en     = i_req.commit & i_req.push & ~pop_bad & ~push_bad;

    always_ff @(posedge i_clk) begin
        if (wr_en) begin
            stack_mem[sp_popped[IDX_W-1:0]] <= i_req.push_data;
        end
    end

    // a failed request leaves the stack as it was
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            sp          <= '0;
            o_overflow  <= 1'b0;
            o_underflow <= 1'b0;
        end else if (i_req.commit) begin
            if (pop_bad) begin
                o_underflow <= 1'b1;
            end else if (push_bad) begin
                o_overflow <= 1'b1;
            end else if (i_req.push) begin
                sp <= sp_popped + wasm_pkg::sp_t'(1);
            end else begin
                sp <= sp_popped;
            end
        end
    end

endmodule

//--- hw/wasm_execute.sv
`timescale 1ns/1ps
`include "wasm_params.svh"

module wasm_execute (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  wasm_pkg::dec_op_t     i_op,
    input  logic                  i_op_vld,
    input  wasm_pkg::run_state_t  i_state,
    input  wasm_pkg::pop_window_t i_window,
    input  logic                  i_rd_en,
    input  wasm_pkg::lmem_addr_t  i_rd_addr,
    output logic                  o_stall,
    output wasm_pkg::stack_req_t  o_req,
    output wasm_pkg::word_t       o_rd_data
);

    wasm_pkg::word_t      lmem [`WASM_LMEM_DEPTH];
    wasm_pkg::word_t      rd_q;
    wasm_pkg::word_t      alu_res;
    wasm_pkg::word_t      addr_base;
    wasm_pkg::word_t      addr_sum;
    wasm_pkg::lmem_addr_t mem_addr;
    wasm_pkg::lmem_addr_t port_addr;
    logic                 bubble;
    logic                 is_load;
    logic                 is_store;
    logic                 in_done;
    logic                 mem_we;
    logic                 mem_re;

    // next OP top
    always_comb begin
        case (i_op.alu)
            wasm_pkg::ALU_SUB: alu_res = i_window.next - i_window.top;
            wasm_pkg::ALU_AND: alu_res = i_window.next & i_window.top;
            wasm_pkg::ALU_OR:  alu_res = i_window.next | i_window.top;
            wasm_pkg::ALU_XOR: alu_res = i_window.next ^ i_window.top;
            default:           alu_res = i_window.next + i_window.top;
        endcase
    end

    assign is_load  = i_op_vld & (i_op.kind == wasm_pkg::KIND_LOAD);
    assign is_store = i_op_vld & (i_op.kind == wasm_pkg::KIND_STORE);
    assign in_done  = (i_state == wasm_pkg::ST_DONE);

    // first cycle of a memory op holds fetch
    assign o_stall = (is_load | is_store) & ~bubble;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            bubble <= 1'b0;
        end else if (bubble) begin
            bubble <= 1'b0;
        end else if (is_load || is_store) begin
            bubble <= 1'b1;
        end
    end

    // store address is the second entry, load address the top
    assign addr_base = is_store ? i_window.next : i_window.top;
    assign addr_sum  = addr_base + i_op.imm;
    assign mem_addr  = addr_sum[`WASM_LMEM_AW+1:2];

    assign port_addr = in_done ? i_rd_addr : mem_addr;
    assign mem_we    = is_store & ~bubble;
    assign mem_re    = (is_load & ~bubble) | (in_done & i_rd_en);

    always_ff @(posedge i_clk) begin
        if (mem_we) begin
            lmem[port_addr] <= i_window.top;
        end
        if (mem_re) begin
            rd_q <= lmem[port_addr];
        end
    end

    assign o_rd_data = in_done ? rd_q : '0;

    always_comb begin
        o_req.commit    = 1'b0;
        o_req.pop_num   = 2'd0;
        o_req.push      = 1'b0;
        o_req.push_data = alu_res;
        if (i_op_vld && !o_stall) begin
            case (i_op.kind)
                wasm_pkg::KIND_CONST: begin
                    o_req.commit    = 1'b1;
                    o_req.push      = 1'b1;
                    o_req.push_data = i_op.imm;
                end
                wasm_pkg::KIND_ALU: begin
                    o_req.commit  = 1'b1;
                    o_req.pop_num = 2'd2;
                    o_req.push    = 1'b1;
                end
                wasm_pkg::KIND_DROP: begin
                    o_req.commit  = 1'b1;
                    o_req.pop_num = 2'd1;
                end
                // read data arrived during the bubble
                wasm_pkg::KIND_LOAD: begin
                    o_req.commit    = 1'b1;
                    o_req.pop_num   = 2'd1;
                    o_req.push      = 1'b1;
                    o_req.push_data = rd_q;
                end
                wasm_pkg::KIND_STORE: begin
                    o_req.commit  = 1'b1;
                    o_req.pop_num = 2'd2;
                end
                default: o_req.commit = 1'b0;
            endcase
        end
    end

endmodule

//--- hw/wasm_core_top.sv
`timescale 1ns/1ps

module wasm_core_top (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_instr_mem_wr_vld,
    input  wasm_pkg::imem_addr_t  i_instr_mem_wr_addr,
    input  wasm_pkg::instr_word_t i_instr_mem_wr_data,
    input  logic                  i_instr_mem_wr_finish,
    input  logic                  i_line_mem_rd_rdy,
    input  wasm_pkg::lmem_addr_t  i_line_mem_rd_addr,
    output logic                  o_instr_mem_wr_rdy,
    output wasm_pkg::run_state_t  o_work_state,
    output wasm_pkg::err_t        o_error,
    output wasm_pkg::word_t       o_line_mem_rd_data
);

    wasm_pkg::dec_op_t     op;
    logic                  op_vld;
    logic                  stall;
    logic                  instr_err;
    wasm_pkg::stack_req_t  stack_req;
    wasm_pkg::pop_window_t window;
    logic                  overflow;
    logic                  underflow;

    assign o_error = {instr_err, overflow, underflow};

    wasm_fetch_decode u_fetch_decode (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_wr_vld    (i_instr_mem_wr_vld),
        .i_wr_addr   (i_instr_mem_wr_addr),
        .i_wr_data   (i_instr_mem_wr_data),
        .i_wr_finish (i_instr_mem_wr_finish),
        .i_stall     (stall),
        .i_stack_err ({overflow, underflow}),
        .o_wr_rdy    (o_instr_mem_wr_rdy),
        .o_state     (o_work_state),
        .o_op        (op),
        .o_op_vld    (op_vld),
        .o_instr_err (instr_err)
    );

    wasm_operand_stack u_operand_stack (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_req       (stack_req),
        .o_window    (window),
        .o_overflow  (overflow),
        .o_underflow (underflow)
    );

    wasm_execute u_execute (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_op      (op),
        .i_op_vld  (op_vld),
        .i_state   (o_work_state),
        .i_window  (window),
        .i_rd_en   (i_line_mem_rd_rdy),
        .i_rd_addr (i_line_mem_rd_addr),
        .o_stall   (stall),
        .o_req     (stack_req),
        .o_rd_data (o_line_mem_rd_data)
    );

endmodule

//--- sim/tb_wasm_core.sv
`timescale 1ns/1ps
`include "wasm_params.svh"

module tb_wasm_core;

    typedef struct packed {
        logic [7:0]      opcode;
        wasm_pkg::word_t imm;
    } row_t;

    // rows and read-back words of one program
    typedef struct packed {
        logic [15:0] start;
        logic [15:0] len;
        logic [15:0] rd_start;
        logic [15:0] rd_cnt;
    } prog_t;

    logic                  i_clk;
    logic                  i_rst_n;
    logic                  i_instr_mem_wr_vld;
    wasm_pkg::imem_addr_t  i_instr_mem_wr_addr;
    wasm_pkg::instr_word_t i_instr_mem_wr_data;
    logic                  i_instr_mem_wr_finish;
    logic                  i_line_mem_rd_rdy;
    wasm_pkg::lmem_addr_t  i_line_mem_rd_addr;
    logic                  o_instr_mem_wr_rdy;
    wasm_pkg::run_state_t  o_work_state;
    wasm_pkg::err_t        o_error;
    wasm_pkg::word_t       o_line_mem_rd_data;

    row_t                 rows [64];
    prog_t                progs [8];
    wasm_pkg::lmem_addr_t reads [16];
    wasm_pkg::word_t      model_mem [`WASM_LMEM_DEPTH];
    wasm_pkg::err_t       model_err;
    int                   n_rows;
    int                   n_progs;
    int                   n_reads;
    integer               seed;
    int                   err_cnt;
    int                   cycle_cnt;
    int                   cycle_limit;

    wasm_core_top i_dut (
        .i_clk                 (i_clk),
        .i_rst_n               (i_rst_n),
        .i_instr_mem_wr_vld    (i_instr_mem_wr_vld),
        .i_instr_mem_wr_addr   (i_instr_mem_wr_addr),
        .i_instr_mem_wr_data   (i_instr_mem_wr_data),
        .i_instr_mem_wr_finish (i_instr_mem_wr_finish),
        .i_line_mem_rd_rdy     (i_line_mem_rd_rdy),
        .i_line_mem_rd_addr    (i_line_mem_rd_addr),
        .o_instr_mem_wr_rdy    (o_instr_mem_wr_rdy),
        .o_work_state          (o_work_state),
        .o_error               (o_error),
        .o_line_mem_rd_data    (o_line_mem_rd_data)
    );

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    task automatic check_word(input wasm_pkg::word_t got, input wasm_pkg::word_t exp,
                              input string what);
        if (got !== exp) begin
            err_cnt++;
            $display("[FAIL] %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_err(input wasm_pkg::err_t got, input wasm_pkg::err_t exp,
                             input string what);
        if (got !== exp) begin
            err_cnt++;
            $display("[FAIL] %0t: %s error flags %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_state(input wasm_pkg::run_state_t got,
                               input wasm_pkg::run_state_t exp, input string what);
        if (got !== exp) begin
            err_cnt++;
            $display("[FAIL] %0t: %s state %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            err_cnt++;
            $display("[FAIL] %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic add_row(input logic [7:0] opcode, input wasm_pkg::word_t imm);
        rows[n_rows] = '{opcode, imm};
        n_rows++;
    endtask

    task automatic add_read(input int byte_addr);
        reads[n_reads] = wasm_pkg::lmem_addr_t'(byte_addr >> 2);
        n_reads++;
    endtask

    task automatic open_prog();
        progs[n_progs].start    = 16'(n_rows);
        progs[n_progs].rd_start = 16'(n_reads);
    endtask

    task automatic close_prog();
        progs[n_progs].len    = 16'(n_rows) - progs[n_progs].start;
        progs[n_progs].rd_cnt = 16'(n_reads) - progs[n_progs].rd_start;
        n_progs++;
    endtask

    task automatic build_table();
        logic [7:0] alu_ops [5];
        alu_ops = '{`WASM_OP_ADD, `WASM_OP_SUB, `WASM_OP_AND, `WASM_OP_OR, `WASM_OP_XOR};
        // address, two random operands, alu op, store
        open_prog();
        for (int k = 0; k < 5; k++) begin
            add_row(`WASM_OP_CONST, wasm_pkg::word_t'(k * 4));
            add_row(`WASM_OP_CONST, wasm_pkg::word_t'($random(seed)));
            add_row(`WASM_OP_CONST, wasm_pkg::word_t'($random(seed)));
            add_row(alu_ops[k], '0);
            add_row(`WASM_OP_STORE, '0);
            add_read(k * 4);
        end
        add_row(`WASM_OP_END, '0);
        close_prog();
        // load back through an offset, add, store elsewhere
        open_prog();
        add_row(`WASM_OP_CONST, 32);
        add_row(`WASM_OP_CONST, wasm_pkg::word_t'($random(seed)));
        add_row(`WASM_OP_STORE, 0);
        add_row(`WASM_OP_CONST, 64);
        add_row(`WASM_OP_CONST, 28);
        add_row(`WASM_OP_LOAD, 4);
        add_row(`WASM_OP_CONST, wasm_pkg::word_t'($random(seed)));
        add_row(`WASM_OP_ADD, 0);
        add_row(`WASM_OP_STORE, 8);
        add_row(`WASM_OP_END, 0);
        add_read(32);
        add_read(72);
        close_prog();
        open_prog();
        add_row(`WASM_OP_CONST, 40);
        add_row(`WASM_OP_CONST, wasm_pkg::word_t'($random(seed)));
        add_row(`WASM_OP_CONST, wasm_pkg::word_t'($random(seed)));
        add_row(`WASM_OP_DROP, 0);
        add_row(`WASM_OP_STORE, 0);
        add_row(`WASM_OP_END, 0);
        add_read(40);
        close_prog();
        // add on a single entry underflows
        open_prog();
        add_row(`WASM_OP_CONST, 48);
        add_row(`WASM_OP_CONST, wasm_pkg::word_t'($random(seed)));
        add_row(`WASM_OP_STORE, 0);
        add_row(`WASM_OP_CONST, wasm_pkg::word_t'($random(seed)));
        add_row(`WASM_OP_ADD, 0);
        add_row(`WASM_OP_CONST, 48);
        add_row(`WASM_OP_CONST, 1);
        add_row(`WASM_OP_STORE, 0);
        add_row(`WASM_OP_END, 0);
        add_read(48);
        close_prog();
        open_prog();
        add_row(`WASM_OP_CONST, 56);
        add_row(`WASM_OP_CONST, wasm_pkg::word_t'($random(seed)));
        add_row(`WASM_OP_STORE, 0);
        add_row(8'hFF, 0);
        add_row(`WASM_OP_CONST, 56);
        add_row(`WASM_OP_CONST, 2);
        add_row(`WASM_OP_STORE, 0);
        add_row(`WASM_OP_END, 0);
        add_read(56);
        close_prog();
    endtask

    function automatic wasm_pkg::word_t alu_ref(input logic [7:0] opcode,
                                                input wasm_pkg::word_t nxt,
                                                input wasm_pkg::word_t top);
        case (opcode)
            `WASM_OP_ADD: return nxt + top;
            `WASM_OP_SUB: return nxt - top;
            `WASM_OP_AND: return nxt & top;
            `WASM_OP_OR:  return nxt | top;
            default:      return nxt ^ top;
        endcase
    endfunction

    // stack machine model that stops at end or at the first error
    task automatic run_model(input int p);
        wasm_pkg::word_t stk [`WASM_STACK_DEPTH];
        wasm_pkg::word_t sum;
        row_t            r;
        int              cnt;
        logic            stop;
        cnt       = 0;
        stop      = 1'b0;
        model_err = '0;
        for (int i = progs[p].start; i < progs[p].start + progs[p].len && !stop; i++) begin
            r = rows[i];
            case (r.opcode)
                `WASM_OP_CONST: begin
                    if (cnt == `WASM_STACK_DEPTH) begin
                        model_err.overflow = 1'b1;
                    end else begin
                        stk[cnt] = r.imm;
                        cnt++;
                    end
                end
                `WASM_OP_ADD, `WASM_OP_SUB, `WASM_OP_AND, `WASM_OP_OR, `WASM_OP_XOR: begin
                    if (cnt < 2) begin
                        model_err.underflow = 1'b1;
                    end else begin
                        stk[cnt-2] = alu_ref(r.opcode, stk[cnt-2], stk[cnt-1]);
                        cnt--;
                    end
                end
                `WASM_OP_DROP: begin
                    if (cnt < 1) model_err.underflow = 1'b1;
                    else cnt--;
                end
                `WASM_OP_LOAD: begin
                    if (cnt < 1) begin
                        model_err.underflow = 1'b1;
                    end else begin
                        sum        = stk[cnt-1] + r.imm;
                        stk[cnt-1] = model_mem[sum[`WASM_LMEM_AW+1:2]];
                    end
                end
                `WASM_OP_STORE: begin
                    if (cnt < 2) begin
                        model_err.underflow = 1'b1;
                    end else begin
                        sum = stk[cnt-2] + r.imm;
                        model_mem[sum[`WASM_LMEM_AW+1:2]] = stk[cnt-1];
                        cnt -= 2;
                    end
                end
                `WASM_OP_END: stop = 1'b1;
                default:      model_err.instr = 1'b1;
            endcase
            if (model_err != '0) stop = 1'b1;
        end
    endtask

    task automatic apply_reset();
        @(negedge i_clk);
        i_rst_n = 1'b0;
        repeat (3) @(negedge i_clk);
        i_rst_n = 1'b1;
    endtask

    task automatic run_prog(input int p);
        row_t                 r;
        wasm_pkg::lmem_addr_t ra;
        apply_reset();
        check_flag(o_instr_mem_wr_rdy, 1'b1, $sformatf("prog %0d write ready after reset", p));
        check_state(o_work_state, wasm_pkg::ST_LOAD, $sformatf("prog %0d after reset", p));
        check_err(o_error, '0, $sformatf("prog %0d after reset", p));
        for (int i = 0; i < progs[p].len; i++) begin
            r = rows[progs[p].start + i];
            i_instr_mem_wr_vld  = 1'b1;
            i_instr_mem_wr_addr = wasm_pkg::imem_addr_t'(i);
            i_instr_mem_wr_data = {r.opcode, 24'h0, r.imm};
            @(negedge i_clk);
        end
        i_instr_mem_wr_vld    = 1'b0;
        i_instr_mem_wr_finish = 1'b1;
        @(negedge i_clk);
        i_instr_mem_wr_finish = 1'b0;
        check_flag(o_instr_mem_wr_rdy, 1'b0, $sformatf("prog %0d write ready in run", p));
        // host reads are blocked until done
        i_line_mem_rd_rdy = 1'b1;
        while (o_work_state != wasm_pkg::ST_DONE) begin
            check_word(o_line_mem_rd_data, '0, $sformatf("prog %0d read before done", p));
            @(negedge i_clk);
        end
        run_model(p);
        check_err(o_error, model_err, $sformatf("prog %0d at done", p));
        for (int j = 0; j < progs[p].rd_cnt; j++) begin
            ra                 = reads[progs[p].rd_start + j];
            i_line_mem_rd_addr = ra;
            @(negedge i_clk);
            check_word(o_line_mem_rd_data, model_mem[ra],
                       $sformatf("prog %0d line word %0d", p, ra));
        end
        check_state(o_work_state, wasm_pkg::ST_DONE, $sformatf("prog %0d after reads", p));
        i_line_mem_rd_rdy = 1'b0;
    endtask

    initial begin
        wait (cycle_limit > 0);
        while (cycle_cnt < cycle_limit) begin
            @(posedge i_clk);
            cycle_cnt++;
        end
        $display("timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        i_rst_n               = 1'b0;
        i_instr_mem_wr_vld    = 1'b0;
        i_instr_mem_wr_addr   = '0;
        i_instr_mem_wr_data   = '0;
        i_instr_mem_wr_finish = 1'b0;
        i_line_mem_rd_rdy     = 1'b0;
        i_line_mem_rd_addr    = '0;
        seed                  = 7283;
        err_cnt               = 0;
        cycle_cnt             = 0;
        n_rows                = 0;
        n_progs               = 0;
        n_reads               = 0;
        build_table();
        // twice the program length plus 30 per program
        for (int p = 0; p < n_progs; p++) begin
            cycle_limit += 2 * progs[p].len + 30;
        end
        for (int p = 0; p < n_progs; p++) begin
            run_prog(p);
        end
        $display("run complete: %0d programs, %0d errors", n_progs, err_cnt);
        if (err_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+hw
hw/wasm_pkg.sv
hw/wasm_fetch_decode.sv
hw/wasm_operand_stack.sv
hw/wasm_execute.sv
hw/wasm_core_top.sv
sim/tb_wasm_core.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_wasm_core \
    -f filelist.f -o tb_wasm_core

./obj_dir/tb_wasm_core > sim.log 2>&1
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    echo "simulation reported errors, see sim.log"
    exit 1
fi
exit 0
